// File: hw/frame_switch_pkg.sv
`default_nettype none

package frame_switch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int data_width = 32;
  localparam int slot_count = 3;

  // Enough bits to name any slot
  localparam int slot_idx_width = (slot_count > 1) ? $clog2(slot_count) : 1;

  typedef logic [slot_idx_width-1:0] slot_idx_t;

  ////////////////////////////////////////////////////////////////////////////
  // Header route codes
  ////////////////////////////////////////////////////////////////////////////

  // Codes below slot_count are also slot indices
  typedef enum logic [1:0] {
    route_dec  = 2'd0,
    route_inc  = 2'd1,
    route_pass = 2'd2,
    route_drop = 2'd3
  } route_e;

  ////////////////////////////////////////////////////////////////////////////
  // Stream word and beat
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [15:0] frame_id;
    logic [13:0] reserved;
    route_e      route;
  } frame_header_t;

  // First beat of a frame reads as a header, the rest as raw data
  typedef union packed {
    logic [data_width-1:0] raw;
    frame_header_t         header;
  } frame_word_u;

  typedef struct packed {
    frame_word_u word;
    logic        last;
  } stream_beat_t;

  // One beat per processing slot
  typedef stream_beat_t [slot_count-1:0] slot_beat_t;

endpackage

`default_nettype wire

// File: hw/rx_router.sv
`default_nettype none
`timescale 1ns/1ps

module rx_router (
  input  logic                         clk,
  input  logic                         reset,

  input  frame_switch_pkg::stream_beat_t in_beat,
  input  logic                         in_valid,
  output logic                         in_ready,

  output frame_switch_pkg::slot_beat_t slot_in_beat,
  output logic [frame_switch_pkg::slot_count-1:0] slot_in_valid,
  input  logic [frame_switch_pkg::slot_count-1:0] slot_in_ready
);

  import frame_switch_pkg::*;

  // Frame tracking
  logic   frame_open;
  route_e open_route;

  logic   is_header;
  route_e cur_route;
  logic   in_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Route selection
  ////////////////////////////////////////////////////////////////////////////

  assign is_header = !frame_open;

  // Header beat routes itself, later beats follow the stored route
  assign cur_route = is_header ? in_beat.word.header.route : open_route;

  always_comb begin
    // Dropped frames are accepted at full rate
    in_ready      = 1'b1;
    slot_in_valid = '0;
    for (int i = 0; i < slot_count; i++) begin
      slot_in_beat[i] = in_beat;
      if (cur_route == route_e'(i)) begin
        slot_in_valid[i] = in_valid;
        in_ready         = slot_in_ready[i];
      end
    end
  end

  assign in_fire = in_valid && in_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Open frame state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_open <= 1'b0;
      open_route <= route_drop;
    end else if (in_fire) begin
      if (in_beat.last) begin
        frame_open <= 1'b0;
      end else begin
        frame_open <= 1'b1;
      end
      if (is_header) begin
        open_route <= cur_route;
      end
    end
  end

  // Never more than one slot offered a beat
  a_slot_valid_onehot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(slot_in_valid)
  );

endmodule

`default_nettype wire

// File: hw/frame_adjust.sv
`default_nettype none
`timescale 1ns/1ps

module frame_adjust #(
  parameter int signed step = 0
) (
  input  logic                           clk,
  input  logic                           reset,

  input  frame_switch_pkg::stream_beat_t in_beat,
  input  logic                           in_valid,
  output logic                           in_ready,

  output frame_switch_pkg::stream_beat_t out_beat,
  output logic                           out_valid,
  input  logic                           out_ready
);

  import frame_switch_pkg::*;

  // Step as a word, wraps modulo 2^data_width
  localparam logic [data_width-1:0] step_word = data_width'(step);

  logic         full;
  logic         next_header;
  stream_beat_t hold_beat;
  logic         in_fire;

  // Accept when empty or the held beat is leaving
  assign in_ready = !full || out_ready;
  assign in_fire  = in_valid && in_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Stage control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      full        <= 1'b0;
      next_header <= 1'b1;
    end else begin
      if (in_fire) begin
        full        <= 1'b1;
        next_header <= in_beat.last;
      end else if (out_ready) begin
        full <= 1'b0;
      end
    end
  end

  // Payload register, header word kept as is
  always_ff @(posedge clk) begin
    if (in_fire) begin
      hold_beat.last <= in_beat.last;
      if (next_header) begin
        hold_beat.word.raw <= in_beat.word.raw;
      end else begin
        hold_beat.word.raw <= in_beat.word.raw + step_word;
      end
    end
  end

  assign out_valid = full;
  assign out_beat  = hold_beat;

  // Held beat is stable under back-pressure
  a_out_stable: assert property (
    @(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  );

endmodule

`default_nettype wire

// File: hw/tx_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module tx_arbiter (
  input  logic                           clk,
  input  logic                           reset,

  input  frame_switch_pkg::slot_beat_t   slot_out_beat,
  input  logic [frame_switch_pkg::slot_count-1:0] slot_out_valid,
  output logic [frame_switch_pkg::slot_count-1:0] slot_out_ready,

  output frame_switch_pkg::stream_beat_t out_beat,
  output logic                           out_valid,
  input  logic                           out_ready
);

  import frame_switch_pkg::*;

  // Grant state
  logic      busy;
  slot_idx_t grant;
  slot_idx_t last_winner;

  slot_idx_t pick;
  logic      pick_valid;
  slot_idx_t sel;
  logic      out_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin pick
  ////////////////////////////////////////////////////////////////////////////

  // Search starts just after the last winner
  always_comb begin
    int cand;
    pick       = '0;
    pick_valid = 1'b0;
    for (int off = slot_count; off >= 1; off--) begin
      cand = (int'(last_winner) + off) % slot_count;
      if (slot_out_valid[cand]) begin
        pick       = slot_idx_t'(cand);
        pick_valid = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output mux
  ////////////////////////////////////////////////////////////////////////////

  assign sel = busy ? grant : pick;

  always_comb begin
    slot_out_ready = '0;
    for (int i = 0; i < slot_count; i++) begin
      if (sel == slot_idx_t'(i)) begin
        slot_out_ready[i] = out_ready;
      end
    end
  end

  assign out_beat  = slot_out_beat[sel];
  assign out_valid = busy ? slot_out_valid[grant] : pick_valid;
  assign out_fire  = out_valid && out_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Frame lock
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      busy        <= 1'b0;
      grant       <= '0;
      // Makes slot 0 first after reset
      last_winner <= slot_idx_t'(slot_count - 1);
    end else if (out_fire) begin
      busy  <= !out_beat.last;
      grant <= sel;
      if (!busy) begin
        last_winner <= sel;
      end
    end
  end

  // Locked grant until the frame is done
  a_grant_locked: assert property (
    @(posedge clk) disable iff (reset)
    busy |=> (grant == $past(grant))
  );

  a_ready_onehot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(slot_out_ready)
  );

endmodule

`default_nettype wire

// File: hw/frame_switch_top.sv
`default_nettype none
`timescale 1ns/1ps

module frame_switch_top (
  input  logic                           clk,
  input  logic                           reset,

  input  frame_switch_pkg::stream_beat_t in_beat,
  input  logic                           in_valid,
  output logic                           in_ready,

  output frame_switch_pkg::stream_beat_t out_beat,
  output logic                           out_valid,
  input  logic                           out_ready
);

  import frame_switch_pkg::*;

  // Router to slots
  slot_beat_t            slot_in_beat;
  logic [slot_count-1:0] slot_in_valid;
  logic [slot_count-1:0] slot_in_ready;

  // Slots to arbiter
  slot_beat_t            slot_out_beat;
  logic [slot_count-1:0] slot_out_valid;
  logic [slot_count-1:0] slot_out_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Receive side
  ////////////////////////////////////////////////////////////////////////////

  rx_router rx_router_inst (
    .clk           (clk),
    .reset         (reset),
    .in_beat       (in_beat),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .slot_in_beat  (slot_in_beat),
    .slot_in_valid (slot_in_valid),
    .slot_in_ready (slot_in_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Processing slots
  ////////////////////////////////////////////////////////////////////////////

  frame_adjust #(.step(-1)) slot_dec (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (slot_in_beat[route_dec]),
    .in_valid  (slot_in_valid[route_dec]),
    .in_ready  (slot_in_ready[route_dec]),
    .out_beat  (slot_out_beat[route_dec]),
    .out_valid (slot_out_valid[route_dec]),
    .out_ready (slot_out_ready[route_dec])
  );

  frame_adjust #(.step(1)) slot_inc (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (slot_in_beat[route_inc]),
    .in_valid  (slot_in_valid[route_inc]),
    .in_ready  (slot_in_ready[route_inc]),
    .out_beat  (slot_out_beat[route_inc]),
    .out_valid (slot_out_valid[route_inc]),
    .out_ready (slot_out_ready[route_inc])
  );

  // Zero step, frame leaves unchanged
  frame_adjust #(.step(0)) slot_pass (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (slot_in_beat[route_pass]),
    .in_valid  (slot_in_valid[route_pass]),
    .in_ready  (slot_in_ready[route_pass]),
    .out_beat  (slot_out_beat[route_pass]),
    .out_valid (slot_out_valid[route_pass]),
    .out_ready (slot_out_ready[route_pass])
  );

  // Transmit side
  tx_arbiter tx_arbiter_inst (
    .clk            (clk),
    .reset          (reset),
    .slot_out_beat  (slot_out_beat),
    .slot_out_valid (slot_out_valid),
    .slot_out_ready (slot_out_ready),
    .out_beat       (out_beat),
    .out_valid      (out_valid),
    .out_ready      (out_ready)
  );

endmodule

`default_nettype wire

// File: dv/tb_frame_switch.sv
`default_nettype none
`timescale 1ns/1ps

module tb_frame_switch;

  import frame_switch_pkg::*;

  localparam int clk_period      = 8;
  localparam int reset_cycles    = 5;
  localparam int random_frames   = 40;
  localparam int frame_total     = 6 + random_frames;
  localparam int max_frame_beats = 9;
  localparam int stall_factor    = 8;
  localparam int quiet_cycles    = 4;
  localparam int timeout_ns      =
    (frame_total * max_frame_beats * stall_factor + 20 * reset_cycles) * clk_period;

  logic         clk = 1'b0;
  logic         reset;
  stream_beat_t in_beat;
  logic         in_valid;
  logic         in_ready;
  stream_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;

  // Reference model, one queue of expected beats per route
  stream_beat_t exp_q[slot_count][$];
  int           exp_total   = 0;
  int           out_count   = 0;
  int           cycle_count = 0;
  bit           stall_mode  = 1'b0;
  bit           use_gaps    = 1'b0;

  // Frame currently leaving the switch
  bit           out_open = 1'b0;
  route_e       out_route;
  stream_beat_t exp_beat;

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  frame_switch_top frame_switch_top_inst (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checking and model
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run;
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s (got %h, expected %h)", $time, what, got, expected);
      abort_run();
    end
  endtask

  // Payload rule per route, header words never get here
  function automatic logic [31:0] adjust_word(input route_e route, input logic [31:0] w);
    case (route)
      route_dec: return w - 32'd1;
      route_inc: return w + 32'd1;
      default:   return w;
    endcase
  endfunction

  task automatic expect_beat(input route_e route, input stream_beat_t b);
    exp_q[route].push_back(b);
    exp_total = exp_total + 1;
  endtask

  // Sink side, sampled mid-cycle where the handshake is settled
  always @(negedge clk) begin
    if (!reset && out_valid && out_ready) begin
      if (!out_open) begin
        out_route = out_beat.word.header.route;
      end
      if (out_route == route_drop) begin
        $display("Error: a frame with the drop route reached the output at %0t ns", $time);
        abort_run();
      end else if (exp_q[out_route].size() == 0) begin
        $display("Error: output beat at %0t ns with no frame expected on route %0d",
                 $time, out_route);
        abort_run();
      end else begin
        exp_beat = exp_q[out_route].pop_front();
        check_value({31'b0, out_beat}, {31'b0, exp_beat}, "output beat {word, last}");
        out_open  = !out_beat.last;
        out_count = out_count + 1;
      end
    end
  end

  // Sink back-pressure, random only in the mixed test
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (stall_mode) begin
        out_ready = ($urandom_range(0, 9) < 6);
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Source side
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_beat(input stream_beat_t b);
    bit taken;
    if (use_gaps) begin
      idle_cycles(int'($urandom_range(0, 2)));
    end
    in_beat  = b;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic send_frame(input route_e route, input logic [15:0] id,
                            input logic [31:0] payload[$]);
    stream_beat_t b;
    stream_beat_t e;
    b.word.header.frame_id = id;
    b.word.header.reserved = 14'($urandom);
    b.word.header.route    = route;
    b.last                 = (payload.size() == 0);
    if (route != route_drop) begin
      expect_beat(route, b);
    end
    send_beat(b);
    for (int i = 0; i < payload.size(); i++) begin
      b.word.raw = payload[i];
      b.last     = (i == payload.size() - 1);
      e          = b;
      e.word.raw = adjust_word(route, payload[i]);
      if (route != route_drop) begin
        expect_beat(route, e);
      end
      send_beat(b);
    end
  endtask

  // Output counts as drained once out_valid stays low for a few cycles
  task automatic wait_drain;
    int quiet;
    quiet = 0;
    while (quiet < quiet_cycles) begin
      @(negedge clk);
      if (out_valid) begin
        quiet = 0;
      end else begin
        quiet = quiet + 1;
      end
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_reset_state;
    stream_beat_t b;
    // Nothing leaves before a frame goes in
    repeat (3) begin
      @(negedge clk);
      check_value(64'(out_valid), 64'd0, "out_valid after reset");
      @(posedge clk);
      #1;
    end
    b.word.header.frame_id = 16'h0001;
    b.word.header.reserved = '0;
    b.word.header.route    = route_dec;
    b.last                 = 1'b1;
    expect_beat(route_dec, b);
    in_beat  = b;
    in_valid = 1'b1;
    @(negedge clk);
    check_value(64'(in_ready), 64'd1, "in_ready for first header");
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    wait_drain();
  endtask

  task automatic dec_inc_frames;
    logic [31:0] words[$];
    // Wrap values at both ends
    words = '{32'h0000_0000, 32'hffff_ffff, 32'h1234_5678};
    words.push_back($urandom);
    send_frame(route_dec, 16'h0010, words);
    send_frame(route_inc, 16'h0011, words);
    wait_drain();
  endtask

  task automatic pass_frames;
    logic [31:0] words[$];
    words = '{32'hdead_beef, 32'h8000_0000, 32'h7fff_ffff};
    send_frame(route_pass, 16'h0020, words);
    // Header-only frame
    words.delete();
    send_frame(route_pass, 16'h0021, words);
    wait_drain();
  endtask

  task automatic drop_then_pass;
    logic [31:0] words[$];
    int          start_cycle;
    int          start_count;
    repeat (5) words.push_back($urandom);
    start_cycle = cycle_count;
    start_count = out_count;
    send_frame(route_drop, 16'h0030, words);
    // One beat per cycle for a swallowed frame
    check_value(64'(cycle_count - start_cycle), 64'd6, "cycles to accept dropped frame");
    send_frame(route_pass, 16'h0031, words);
    wait_drain();
    check_value(64'(out_count - start_count), 64'd6, "beats out after drop and pass");
  endtask

  task automatic random_mix;
    logic [31:0] words[$];
    int          len;
    route_e      route;
    use_gaps   = 1'b1;
    stall_mode = 1'b1;
    for (int f = 0; f < random_frames; f++) begin
      route = route_e'(2'($urandom_range(0, 3)));
      len   = int'($urandom_range(0, max_frame_beats - 1));
      words.delete();
      repeat (len) words.push_back($urandom);
      send_frame(route, 16'(16'h0100 + f), words);
    end
    use_gaps   = 1'b0;
    stall_mode = 1'b0;
    wait_drain();
    check_value(64'(out_count), 64'(exp_total), "total output beats");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #(timeout_ns);
    $display("Error: timeout, the tests did not finish within %0d ns", timeout_ns);
    abort_run();
  end

  initial begin
    void'($urandom(32'h0df5_e394));
    reset    = 1'b1;
    in_beat  = '0;
    in_valid = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    check_reset_state();
    dec_inc_frames();
    pass_frames();
    drop_then_pass();
    random_mix();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/frame_switch_pkg.sv
hw/rx_router.sv
hw/frame_adjust.sv
hw/tx_arbiter.sv
hw/frame_switch_top.sv
dv/tb_frame_switch.sv

// File: Makefile
# Verilator build and run of the frame switch testbench

TOP = tb_frame_switch

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
